// File: include/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// Physical register file
`define PREG_SIZE   64  // Number of physical registers
`define PREG_WIDTH  6   // Bits in a physical register index

// ROB walk
`define WALK_LANES  2   // Walk entries delivered per cycle

`endif

// File: hw/rename_pkg.sv
`include "ooo_consts.svh"

package rename_pkg;

    // One source operand as presented to the busy table
    typedef struct packed {
        logic [`PREG_WIDTH-1:0] idx;     // Physical source register
        logic                   is_reg;  // Operand comes from a register
    } src_lookup_t;

    // One instruction of a dispatch group
    typedef struct packed {
        logic                   valid;
        logic                   rd_en;   // Writes a destination
        logic [`PREG_WIDTH-1:0] rd;      // Allocated destination
        src_lookup_t            rs1;
        src_lookup_t            rs2;
    } instr_disp_t;

    // Two-wide group, instr0 is the older one
    typedef struct packed {
        instr_disp_t instr0;
        instr_disp_t instr1;
    } disp_group_t;

    // Bit order matches the four lookup ports, instr0 src1 on top
    typedef struct packed {
        logic instr0_src1;
        logic instr0_src2;
        logic instr1_src1;
        logic instr1_src2;
    } src_busy_t;

    // Writeback free, also reused for allocation and walk sets
    typedef struct packed {
        logic                   en;
        logic [`PREG_WIDTH-1:0] rd;
    } preg_free_t;

endpackage

// File: hw/rob_pkg.sv
`include "ooo_consts.svh"

package rob_pkg;

    // Recovery state of the ROB
    typedef enum logic [1:0] {
        rob_idle     = 2'd0,  // Normal dispatch
        rob_rollback = 2'd1,  // Single cycle, table is wiped
        rob_walk     = 2'd2   // Busy bits rebuilt from walk entries
    } rob_state_e;

    // One ROB entry seen during the walk
    typedef struct packed {
        logic                   valid;
        logic                   complete;  // Result already written back
        logic [`PREG_WIDTH-1:0] prd;       // Destination of the entry
        logic                   last;      // Final entry of the walk
    } walk_lane_t;

endpackage

// File: hw/busy_table.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module busy_table (
    input  logic                                        clock,
    input  logic                                        rst_n,

    input  logic                                        clear_all,  // Rollback wipe
    input  rename_pkg::preg_free_t [1:0]                alloc,      // Dispatch destinations
    input  rename_pkg::preg_free_t [`WALK_LANES-1:0]    walk_set,   // Rebuild during walk
    input  rename_pkg::preg_free_t                      int_free,   // Integer writeback
    input  rename_pkg::preg_free_t                      mem_free,   // Memory writeback

    input  rename_pkg::src_lookup_t [3:0]               lookup,     // [3] is instr0 src1
    output rename_pkg::src_busy_t                       busy
);

    logic [`PREG_SIZE-1:0] busy_bits;  // One means result still pending
    logic [3:0]            busy_vec;
    logic [3:0]            int_hit;
    logic [3:0]            mem_hit;

    // Sets first, then clears, so a same-cycle writeback wins
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy_bits <= '0;
        end else if (clear_all) begin
            busy_bits <= '0;  // Everything ready again
        end else begin
            for (int a = 0; a < 2; a++) begin
                if (alloc[a].en) begin
                    busy_bits[alloc[a].rd] <= 1'b1;
                end
            end
            for (int w = 0; w < `WALK_LANES; w++) begin
                if (walk_set[w].en) begin
                    busy_bits[walk_set[w].rd] <= 1'b1;
                end
            end
            if (int_free.en) begin
                busy_bits[int_free.rd] <= 1'b0;
            end
            if (mem_free.en) begin
                busy_bits[mem_free.rd] <= 1'b0;
            end
        end
    end

    // Writeback bypass into the lookups
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            int_hit[k] = int_free.en & (int_free.rd == lookup[k].idx);
            mem_hit[k] = mem_free.en & (mem_free.rd == lookup[k].idx);
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            busy_vec[k] = lookup[k].is_reg
                        & busy_bits[lookup[k].idx]
                        & ~int_hit[k]
                        & ~mem_hit[k];  // Freed this cycle reads ready
        end
    end

    assign busy = busy_vec;

endmodule

// File: hw/dispatch_ctrl.sv
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic                              clock,
    input  logic                              rst_n,

    input  logic                              disp_req,
    input  rename_pkg::disp_group_t           disp_group,  // Stable while disp_req is high
    input  rob_pkg::rob_state_e               walk_state,
    output logic                              disp_ack,
    output rename_pkg::src_busy_t             disp_busy,   // Valid while disp_ack is high

    output rename_pkg::src_lookup_t [3:0]     lookup,
    output rename_pkg::preg_free_t  [1:0]     alloc,
    input  rename_pkg::src_busy_t             table_busy
);

    logic                  accept;
    logic                  dep_src1;
    logic                  dep_src2;
    rename_pkg::src_busy_t busy_next;

    // A source of an invalid slot never reports busy
    function automatic rename_pkg::src_lookup_t gate_src(
        input logic                    slot_valid,
        input rename_pkg::src_lookup_t src
    );
        rename_pkg::src_lookup_t res;
        res        = src;
        res.is_reg = src.is_reg & slot_valid;
        return res;
    endfunction

    // New request only in idle and after the previous ack dropped
    assign accept = disp_req & ~disp_ack & (walk_state == rob_pkg::rob_idle);

    assign lookup[3] = gate_src(disp_group.instr0.valid, disp_group.instr0.rs1);
    assign lookup[2] = gate_src(disp_group.instr0.valid, disp_group.instr0.rs2);
    assign lookup[1] = gate_src(disp_group.instr1.valid, disp_group.instr1.rs1);
    assign lookup[0] = gate_src(disp_group.instr1.valid, disp_group.instr1.rs2);

    assign alloc[0].en = accept & disp_group.instr0.valid & disp_group.instr0.rd_en;
    assign alloc[0].rd = disp_group.instr0.rd;
    assign alloc[1].en = accept & disp_group.instr1.valid & disp_group.instr1.rd_en;
    assign alloc[1].rd = disp_group.instr1.rd;

    // instr1 reading instr0's destination, unknown to the table yet
    assign dep_src1 = alloc[0].en & lookup[1].is_reg
                    & (lookup[1].idx == disp_group.instr0.rd);
    assign dep_src2 = alloc[0].en & lookup[0].is_reg
                    & (lookup[0].idx == disp_group.instr0.rd);

    always_comb begin
        busy_next             = table_busy;
        busy_next.instr1_src1 = table_busy.instr1_src1 | dep_src1;
        busy_next.instr1_src2 = table_busy.instr1_src2 | dep_src2;
    end

    // Four-phase handshake, ack follows req down one cycle later
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            disp_ack <= 1'b0;
        end else if (accept) begin
            disp_ack <= 1'b1;
        end else if (disp_ack && !disp_req) begin
            disp_ack <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            disp_busy <= busy_next;  // Held for the whole ack phase
        end
    end

endmodule

// File: hw/rob_walk_ctrl.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rob_walk_ctrl (
    input  logic                                      clock,
    input  logic                                      rst_n,

    input  logic                                      flush_valid,  // One-cycle pulse
    input  rob_pkg::walk_lane_t    [`WALK_LANES-1:0]  walk_lanes,
    output rob_pkg::rob_state_e                       walk_state,
    output logic                                      clear_all,
    output rename_pkg::preg_free_t [`WALK_LANES-1:0]  walk_set
);

    rob_pkg::rob_state_e state;
    rob_pkg::rob_state_e state_next;
    logic                walk_done;

    always_comb begin
        walk_done = 1'b0;
        for (int i = 0; i < `WALK_LANES; i++) begin
            walk_done = walk_done | (walk_lanes[i].valid & walk_lanes[i].last);
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            rob_pkg::rob_idle: begin
                if (flush_valid) begin
                    state_next = rob_pkg::rob_rollback;
                end
            end
            rob_pkg::rob_rollback: state_next = rob_pkg::rob_walk;  // Always one cycle
            rob_pkg::rob_walk: begin
                if (walk_done) begin
                    state_next = rob_pkg::rob_idle;
                end
            end
            default: state_next = rob_pkg::rob_idle;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= rob_pkg::rob_idle;
        end else begin
            state <= state_next;
        end
    end

    // Only entries still in flight become busy again
    always_comb begin
        for (int i = 0; i < `WALK_LANES; i++) begin
            walk_set[i].en = (state == rob_pkg::rob_walk)
                           & walk_lanes[i].valid & ~walk_lanes[i].complete;
            walk_set[i].rd = walk_lanes[i].prd;
        end
    end

    assign clear_all  = (state == rob_pkg::rob_rollback);
    assign walk_state = state;

endmodule

// File: hw/busy_unit_top.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module busy_unit_top (
    input  logic                                   clock,
    input  logic                                   rst_n,

    input  logic                                   disp_req,
    input  rename_pkg::disp_group_t                disp_group,
    output logic                                   disp_ack,
    output rename_pkg::src_busy_t                  disp_busy,

    input  rename_pkg::preg_free_t                 int_free,
    input  rename_pkg::preg_free_t                 mem_free,

    input  logic                                   flush_valid,
    input  rob_pkg::walk_lane_t [`WALK_LANES-1:0]  walk_lanes,
    output rob_pkg::rob_state_e                    walk_state
);

    rename_pkg::src_lookup_t [3:0]             lookup;
    rename_pkg::preg_free_t  [1:0]             alloc;
    rename_pkg::src_busy_t                     table_busy;
    rename_pkg::preg_free_t  [`WALK_LANES-1:0] walk_set;
    logic                                      clear_all;

    busy_table busy_table_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .clear_all (clear_all),
        .alloc     (alloc),
        .walk_set  (walk_set),
        .int_free  (int_free),
        .mem_free  (mem_free),
        .lookup    (lookup),
        .busy      (table_busy)
    );

    dispatch_ctrl dispatch_ctrl_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .disp_req   (disp_req),
        .disp_group (disp_group),
        .walk_state (walk_state),  // Holds dispatch off during recovery
        .disp_ack   (disp_ack),
        .disp_busy  (disp_busy),
        .lookup     (lookup),
        .alloc      (alloc),
        .table_busy (table_busy)
    );

    rob_walk_ctrl rob_walk_ctrl_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .flush_valid (flush_valid),
        .walk_lanes  (walk_lanes),
        .walk_state  (walk_state),
        .clear_all   (clear_all),
        .walk_set    (walk_set)
    );

endmodule

// File: verification/busy_unit_props.sv
`timescale 1ns/1ps

module busy_unit_props (
    input logic                clock,
    input logic                rst_n,
    input logic                disp_req,
    input logic                disp_ack,
    input rob_pkg::rob_state_e walk_state
);

    ack_after_req: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(disp_ack) |-> $past(disp_req))
        else $error("disp_ack rose without a pending request");

    // Four-phase, ack drops only once req is gone
    ack_fall_after_req: assert property (@(posedge clock) disable iff (!rst_n)
        $fell(disp_ack) |-> !$past(disp_req))
        else $error("disp_ack fell while disp_req was still high");

    rollback_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        (walk_state == rob_pkg::rob_rollback) |=> (walk_state == rob_pkg::rob_walk))
        else $error("rollback did not move to walk after one cycle");

    ack_only_in_idle: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(disp_ack) |-> ($past(walk_state) == rob_pkg::rob_idle))
        else $error("disp_ack rose outside the idle state");

endmodule

// File: verification/busy_unit_tb.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module busy_unit_tb;

    localparam int         CLK_PERIOD = 100;
    localparam logic [1:0] OP_IDLE    = 2'd0;
    localparam logic [1:0] OP_DISP    = 2'd1;
    localparam logic [1:0] OP_FREE    = 2'd2;
    localparam logic [1:0] OP_FLUSH   = 2'd3;  // Flush and two walk cycles before dispatch

    typedef struct packed {
        logic [1:0]                op;
        logic                      use_model;  // Expected value taken from the model
        rename_pkg::disp_group_t   group;
        rename_pkg::preg_free_t    ifree;
        rename_pkg::preg_free_t    mfree;
        rob_pkg::walk_lane_t [3:0] lanes;      // Two cycles of two lanes
        rename_pkg::src_busy_t     exp;
    } step_t;

    logic                                  clock;
    logic                                  rst_n;
    logic                                  disp_req;
    rename_pkg::disp_group_t               disp_group;
    logic                                  disp_ack;
    rename_pkg::src_busy_t                 disp_busy;
    rename_pkg::preg_free_t                int_free;
    rename_pkg::preg_free_t                mem_free;
    logic                                  flush_valid;
    rob_pkg::walk_lane_t [`WALK_LANES-1:0] walk_lanes;
    rob_pkg::rob_state_e                   walk_state;

    step_t                 steps[$];
    string                 names[$];
    logic [`PREG_SIZE-1:0] model;  // Reference busy bits
    integer                seed = 32'h805;
    int                    n_pass;
    int                    n_fail;
    bit                    table_ready;
    bit                    ok;

    busy_unit_top busy_unit_top_inst (.*);

    bind busy_unit_top busy_unit_props busy_unit_props_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .disp_req   (disp_req),
        .disp_ack   (disp_ack),
        .walk_state (walk_state)
    );

    function automatic rename_pkg::instr_disp_t make_instr(
        input logic rd_en, input logic [`PREG_WIDTH-1:0] rd,
        input logic [`PREG_WIDTH-1:0] s1, input logic s1_reg,
        input logic [`PREG_WIDTH-1:0] s2, input logic s2_reg
    );
        return '{valid: 1'b1, rd_en: rd_en, rd: rd,
                 rs1: '{idx: s1, is_reg: s1_reg}, rs2: '{idx: s2, is_reg: s2_reg}};
    endfunction

    // Indices kept to 0..15 so hits on busy registers are common
    function automatic rename_pkg::instr_disp_t random_instr(input logic [31:0] w);
        return make_instr(w[0], {2'b00, w[4:1]}, {2'b00, w[8:5]}, w[9],
                          {2'b00, w[13:10]}, w[14]);
    endfunction

    function automatic rob_pkg::walk_lane_t make_lane(
        input logic complete, input logic [`PREG_WIDTH-1:0] prd, input logic last
    );
        return '{valid: 1'b1, complete: complete, prd: prd, last: last};
    endfunction

    function automatic rename_pkg::src_busy_t predict(input rename_pkg::disp_group_t g,
        input rename_pkg::preg_free_t fi, input rename_pkg::preg_free_t fm);
        rename_pkg::src_lookup_t src [4];
        logic [3:0]              vld;
        logic [3:0]              res;
        src = '{g.instr1.rs2, g.instr1.rs1, g.instr0.rs2, g.instr0.rs1};  // Index 3 is instr0 src1
        vld = {g.instr0.valid, g.instr0.valid, g.instr1.valid, g.instr1.valid};
        for (int k = 0; k < 4; k++) begin
            res[k] = vld[k] && src[k].is_reg && model[src[k].idx]
                   && !(fi.en && fi.rd == src[k].idx) && !(fm.en && fm.rd == src[k].idx);
        end
        if (g.instr0.valid && g.instr0.rd_en) begin  // Dependency inside the group
            res[1] = res[1] | (vld[1] && src[1].is_reg && src[1].idx == g.instr0.rd);
            res[0] = res[0] | (vld[0] && src[0].is_reg && src[0].idx == g.instr0.rd);
        end
        return res;
    endfunction

    // Allocations set before writebacks clear
    function automatic void commit(input rename_pkg::disp_group_t g,
        input rename_pkg::preg_free_t fi, input rename_pkg::preg_free_t fm);
        if (g.instr0.valid && g.instr0.rd_en) model[g.instr0.rd] = 1'b1;
        if (g.instr1.valid && g.instr1.rd_en) model[g.instr1.rd] = 1'b1;
        if (fi.en) model[fi.rd] = 1'b0;
        if (fm.en) model[fm.rd] = 1'b0;
    endfunction

    task automatic check_state(input string name, input rob_pkg::rob_state_e exp_state,
        inout bit passed);
        assert (walk_state == exp_state) else begin
            $display("FAILED %s expected %s actual %s", name, exp_state.name(),
                     walk_state.name());
            passed = 1'b0;
        end
    endtask

    task automatic add_step(input string name, input logic [1:0] op,
        input rename_pkg::disp_group_t g, input rename_pkg::preg_free_t fi,
        input rename_pkg::preg_free_t fm, input rob_pkg::walk_lane_t [3:0] lanes,
        input rename_pkg::src_busy_t exp, input logic use_model);
        steps.push_back('{op: op, use_model: use_model, group: g, ifree: fi, mfree: fm,
                          lanes: lanes, exp: exp});
        names.push_back(name);
    endtask

    task automatic build_table();
        rename_pkg::disp_group_t   g;
        rob_pkg::walk_lane_t [3:0] lanes;
        logic [31:0]               w0;
        logic [31:0]               w1;
        g.instr0 = make_instr(1'b1, 6'd10, 6'd1, 1'b1, 6'd2, 1'b1);
        g.instr1 = make_instr(1'b1, 6'd11, 6'd3, 1'b1, 6'd4, 1'b1);
        add_step("reset_ready", OP_DISP, g, '0, '0, '0, 4'b0000, 1'b0);
        g.instr0 = make_instr(1'b0, 6'd0, 6'd10, 1'b1, 6'd11, 1'b1);
        g.instr1 = make_instr(1'b0, 6'd0, 6'd10, 1'b0, 6'd5, 1'b1);  // Not a register
        add_step("alloc_busy", OP_DISP, g, '0, '0, '0, 4'b1100, 1'b0);
        g.instr0 = make_instr(1'b1, 6'd20, 6'd1, 1'b1, 6'd2, 1'b1);
        g.instr1 = make_instr(1'b1, 6'd21, 6'd20, 1'b1, 6'd10, 1'b1);
        add_step("intra_dep", OP_DISP, g, '0, '0, '0, 4'b0011, 1'b0);
        add_step("int_free", OP_FREE, '0, '{en: 1'b1, rd: 6'd10}, '0, '0, '0, 1'b0);
        g.instr0 = make_instr(1'b0, 6'd0, 6'd10, 1'b1, 6'd11, 1'b1);
        g.instr1 = make_instr(1'b0, 6'd0, 6'd20, 1'b1, 6'd21, 1'b1);
        add_step("free_bypass", OP_DISP, g, '{en: 1'b1, rd: 6'd21}, '{en: 1'b1, rd: 6'd11},
                 '0, 4'b0010, 1'b0);
        g.instr1 = make_instr(1'b0, 6'd0, 6'd32, 1'b1, 6'd20, 1'b1);
        g.instr0 = make_instr(1'b0, 6'd0, 6'd30, 1'b1, 6'd31, 1'b1);
        lanes = {rob_pkg::walk_lane_t'('0), make_lane(1'b0, 6'd32, 1'b1),
                 make_lane(1'b1, 6'd31, 1'b0), make_lane(1'b0, 6'd30, 1'b0)};
        add_step("walk_rebuild", OP_FLUSH, g, '0, '0, lanes, 4'b1010, 1'b0);
        for (int r = 0; r < 8; r++) begin
            w0 = $random(seed);
            w1 = $random(seed);
            g.instr0 = random_instr(w0);
            g.instr1 = random_instr(w1);
            add_step($sformatf("random_%0d", r), OP_DISP, g,
                     '{en: w0[15], rd: {2'b00, w0[19:16]}},
                     '{en: w1[15], rd: {2'b00, w1[19:16]}}, '0, '0, 1'b1);
        end
        add_step("settle", OP_IDLE, '0, '0, '0, '0, '0, 1'b0);
    endtask

    task automatic run_step(input int i, output bit passed);
        step_t                 s;
        rename_pkg::src_busy_t exp;
        rob_pkg::rob_state_e   exp_state;
        s      = steps[i];
        passed = 1'b1;
        if (s.op == OP_IDLE) begin
            repeat (2) @(posedge clock);
            #1;
            check_state(names[i], rob_pkg::rob_idle, passed);
            assert (!disp_ack) else begin
                $display("%s: dispatch was acknowledged with no request pending", names[i]);
                passed = 1'b0;
            end
        end
        if (s.op == OP_FREE) begin
            int_free = s.ifree;
            mem_free = s.mfree;
            @(posedge clock);
            #1;
            int_free = '0;
            mem_free = '0;
            commit('0, s.ifree, s.mfree);
        end
        if (s.op == OP_FLUSH) begin
            flush_valid = 1'b1;
            @(posedge clock);
            #1;
            check_state(names[i], rob_pkg::rob_rollback, passed);
            flush_valid = 1'b0;
            disp_group  = s.group;
            disp_req    = 1'b1;  // Raised in rollback so the ack has to wait for idle
            model       = '0;
            @(posedge clock);
            #1;
            check_state(names[i], rob_pkg::rob_walk, passed);
            for (int c = 0; c < 2; c++) begin
                walk_lanes = s.lanes[2*c +: 2];
                @(posedge clock);
                #1;
                assert (!disp_ack) else begin
                    $display("%s: dispatch was acknowledged during the ROB walk", names[i]);
                    passed = 1'b0;
                end
                exp_state = rob_pkg::rob_walk;
                for (int l = 2 * c; l < 2 * c + 2; l++) begin
                    if (s.lanes[l].valid && !s.lanes[l].complete) begin
                        model[s.lanes[l].prd] = 1'b1;
                    end
                    if (s.lanes[l].valid && s.lanes[l].last) begin
                        exp_state = rob_pkg::rob_idle;  // Last entry ends the walk
                    end
                end
                check_state(names[i], exp_state, passed);
            end
            walk_lanes = '0;
        end
        if (s.op == OP_DISP || s.op == OP_FLUSH) begin
            if (s.op == OP_DISP) begin
                disp_group = s.group;
                int_free   = s.ifree;
                mem_free   = s.mfree;
                disp_req   = 1'b1;
            end
            exp = predict(s.group, s.ifree, s.mfree);
            if (!s.use_model) begin
                assert (s.exp == exp) else begin
                    $display("FAILED %s expected %b actual %b in the step table",
                             names[i], exp, s.exp);
                    passed = 1'b0;
                end
            end
            do begin
                @(posedge clock);
                #1;
                int_free = '0;  // Frees last one cycle only
                mem_free = '0;
            end while (!disp_ack);
            commit(s.group, s.ifree, s.mfree);
            assert (disp_busy === exp) else begin
                $display("FAILED %s expected %b actual %b", names[i], exp, disp_busy);
                passed = 1'b0;
            end
            disp_req = 1'b0;
            do begin
                @(posedge clock);
                #1;
            end while (disp_ack);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        wait (table_ready);
        repeat (steps.size() * 20) @(posedge clock);
        $display("Watchdog expired, tests did not finish in %0d cycles", steps.size() * 20);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        disp_req    = 1'b0;
        disp_group  = '0;
        int_free    = '0;
        mem_free    = '0;
        flush_valid = 1'b0;
        walk_lanes  = '0;
        model       = '0;
        n_pass      = 0;
        n_fail      = 0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(i, ok);
            if (ok) begin
                n_pass++;
                $display("passed %s", names[i]);
            end else begin
                n_fail++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed", steps.size(), n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
hw/rename_pkg.sv
hw/rob_pkg.sv
hw/busy_table.sv
hw/dispatch_ctrl.sv
hw/rob_walk_ctrl.sv
hw/busy_unit_top.sv
verification/busy_unit_props.sv
verification/busy_unit_tb.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module busy_unit_tb -o busy_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/busy_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
